// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Byte address and one 32-bit instruction
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // Memory word with two instructions, low half at the lower address
    typedef logic [63:0] word_t;

    // Entry or pop count, 0 to 4
    typedef logic [2:0] count_t;

    typedef enum logic [1:0] {
        idle,
        busy,
        drain
    } fetch_state_t;

    localparam addr_t RESET_VECTOR = 32'h0000_1000;

    localparam int BUFFER_DEPTH = 4;

    // Control-transfer opcodes that end a dual issue
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR = 7'b1100111;

endpackage

`default_nettype wire

// File: src/fetch_fill_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fetch_fill_if;
    import fetch_pkg::*;

    logic fill;
    addr_t fill_pc;
    word_t fill_data;
    logic flush;
    // Two or more free entries in the buffer
    logic room;

    modport source (
        output fill,
        output fill_pc,
        output fill_data,
        output flush,
        input room
    );

    modport sink (
        input fill,
        input fill_pc,
        input fill_data,
        input flush,
        output room
    );

endinterface

`default_nettype wire

// File: src/slot_pair_if.sv
`timescale 1ns/10ps
`default_nettype none

interface slot_pair_if;
    import fetch_pkg::*;

    // Oldest two buffer entries
    logic valid0;
    addr_t pc0;
    instr_t instr0;
    logic valid1;
    addr_t pc1;
    instr_t instr1;
    // Entries removed at the next edge
    count_t pop;

    modport head (
        output valid0,
        output pc0,
        output instr0,
        output valid1,
        output pc1,
        output instr1,
        input pop
    );

    modport taker (
        input valid0,
        input pc0,
        input instr0,
        input valid1,
        input pc1,
        input instr1,
        output pop
    );

endinterface

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input wire clock,
    input wire reset,
    output logic imem_valid,
    output fetch_pkg::addr_t imem_addr,
    input wire imem_ready,
    input wire fetch_pkg::word_t imem_rdata,
    input wire trap,
    input wire fetch_pkg::addr_t mtvec,
    input wire mret,
    input wire fetch_pkg::addr_t mepc,
    input wire pred_miss,
    input wire fetch_pkg::addr_t miss_addr,
    input wire fence,
    input wire fetch_pkg::addr_t fence_npc,
    fetch_fill_if.source fill
);
    import fetch_pkg::*;

    fetch_state_t state;
    addr_t pc;
    addr_t stale_addr;
    addr_t redirect_pc;
    addr_t seq_pc;
    logic redirect;
    logic accept;

    assign redirect = trap | mret | pred_miss | fence;

    // trap > mret > pred_miss > fence
    always_comb begin
        if (trap) begin
            redirect_pc = mtvec;
        end else if (mret) begin
            redirect_pc = mepc;
        end else if (pred_miss) begin
            redirect_pc = miss_addr;
        end else begin
            redirect_pc = fence_npc;
        end
    end

    // Next word boundary, also when pc points at a high half
    assign seq_pc = {pc[31:3], 3'b000} + 32'd8;

    always_comb begin
        case (state)
            busy: imem_valid = fill.room;
            // The stale request stays up until the memory answers
            drain: imem_valid = 1'b1;
            default: imem_valid = 1'b0;
        endcase
    end

    assign imem_addr = (state == drain) ? stale_addr : {pc[31:3], 3'b000};

    assign accept = (state == busy) && imem_valid && imem_ready;

    assign fill.fill = accept;
    assign fill.fill_pc = pc;
    assign fill.fill_data = imem_rdata;
    assign fill.flush = redirect;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            pc <= RESET_VECTOR;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (accept) begin
                pc <= seq_pc;
            end
            case (state)
                idle: begin
                    state <= busy;
                end
                busy: begin
                    if (redirect && imem_valid && !imem_ready) begin
                        state <= drain;
                    end
                end
                drain: begin
                    if (imem_ready) begin
                        state <= busy;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Address of the request left in flight by a redirect
    always_ff @(posedge clock) begin
        if (state == busy && redirect) begin
            stale_addr <= imem_addr;
        end
    end

    // A pending request keeps its address across redirects and drain
    property p_request_hold;
        @(posedge clock) disable iff (!reset)
            imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr);
    endproperty
    assert property (p_request_hold);

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer (
    input wire clock,
    input wire reset,
    fetch_fill_if.sink fill,
    slot_pair_if.head head
);
    import fetch_pkg::*;

    instr_t instr_mem [BUFFER_DEPTH];
    addr_t pc_mem [BUFFER_DEPTH];
    logic [$clog2(BUFFER_DEPTH)-1:0] rd_ptr;
    logic [$clog2(BUFFER_DEPTH)-1:0] rd_next;
    logic [$clog2(BUFFER_DEPTH)-1:0] wr_ptr;
    logic [$clog2(BUFFER_DEPTH)-1:0] wr_next;
    count_t count;
    count_t n_write;
    addr_t pc_lo;
    addr_t pc_hi;
    logic write;

    assign write = fill.fill && !fill.flush;

    // A fetch aimed at a high half keeps only that half
    assign n_write = fill.fill_pc[2] ? 3'd1 : 3'd2;
    assign pc_lo = {fill.fill_pc[31:3], 1'b0, fill.fill_pc[1:0]};
    assign pc_hi = {fill.fill_pc[31:3], 1'b1, fill.fill_pc[1:0]};

    assign rd_next = rd_ptr + 1'b1;
    assign wr_next = wr_ptr + 1'b1;

    always_ff @(posedge clock) begin
        if (write) begin
            if (fill.fill_pc[2]) begin
                instr_mem[wr_ptr] <= fill.fill_data[63:32];
                pc_mem[wr_ptr] <= pc_hi;
            end else begin
                instr_mem[wr_ptr] <= fill.fill_data[31:0];
                pc_mem[wr_ptr] <= pc_lo;
                instr_mem[wr_next] <= fill.fill_data[63:32];
                pc_mem[wr_next] <= pc_hi;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset || fill.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            rd_ptr <= rd_ptr + head.pop[1:0];
            if (write) begin
                wr_ptr <= wr_ptr + n_write[1:0];
            end
            count <= count + (write ? n_write : 3'd0) - head.pop;
        end
    end

    assign fill.room = (count <= count_t'(BUFFER_DEPTH - 2));

    assign head.valid0 = (count != 3'd0);
    assign head.pc0 = pc_mem[rd_ptr];
    assign head.instr0 = instr_mem[rd_ptr];
    assign head.valid1 = (count > 3'd1);
    assign head.pc1 = pc_mem[rd_next];
    assign head.instr1 = instr_mem[rd_next];

    // The fetch stage only returns words it asked for with room
    assert property (@(posedge clock) disable iff (!reset)
        fill.fill |-> fill.room);

    // Issue never takes more than the queue holds
    assert property (@(posedge clock) disable iff (!reset)
        head.pop <= count);

endmodule

`default_nettype wire

// File: src/issue_unit.sv
`timescale 1ns/10ps
`default_nettype none

module issue_unit (
    slot_pair_if.taker issue,
    input wire issue_ready,
    output logic issue0_valid,
    output fetch_pkg::addr_t issue0_pc,
    output fetch_pkg::instr_t issue0_instr,
    output logic issue1_valid,
    output fetch_pkg::addr_t issue1_pc,
    output fetch_pkg::instr_t issue1_instr
);
    import fetch_pkg::*;

    logic [6:0] opcode0;
    logic ctrl0;

    assign opcode0 = issue.instr0[6:0];

    // Branch or jump in slot 0 goes out alone
    assign ctrl0 = (opcode0 == OPCODE_BRANCH) ||
                   (opcode0 == OPCODE_JAL) ||
                   (opcode0 == OPCODE_JALR);

    assign issue0_valid = issue.valid0;
    assign issue0_pc = issue.pc0;
    assign issue0_instr = issue.instr0;

    assign issue1_valid = issue.valid1 && !ctrl0;
    assign issue1_pc = issue.pc1;
    assign issue1_instr = issue.instr1;

    // Every offered slot leaves the buffer when the consumer is ready
    always_comb begin
        if (issue_ready) begin
            issue.pop = count_t'(issue0_valid) + count_t'(issue1_valid);
        end else begin
            issue.pop = '0;
        end
    end

    // Relies on the buffer never showing entry 1 without entry 0
    always_comb begin
        assert (!issue1_valid || issue0_valid);
    end

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input wire clock,
    input wire reset,
    output logic imem_valid,
    output fetch_pkg::addr_t imem_addr,
    input wire imem_ready,
    input wire fetch_pkg::word_t imem_rdata,
    input wire trap,
    input wire fetch_pkg::addr_t mtvec,
    input wire mret,
    input wire fetch_pkg::addr_t mepc,
    input wire pred_miss,
    input wire fetch_pkg::addr_t miss_addr,
    input wire fence,
    input wire fetch_pkg::addr_t fence_npc,
    input wire issue_ready,
    output logic issue0_valid,
    output fetch_pkg::addr_t issue0_pc,
    output fetch_pkg::instr_t issue0_instr,
    output logic issue1_valid,
    output fetch_pkg::addr_t issue1_pc,
    output fetch_pkg::instr_t issue1_instr
);

    fetch_fill_if fill_bus ();
    slot_pair_if slot_bus ();

    fetch_stage u_fetch_stage (
        .clock(clock),
        .reset(reset),
        .imem_valid(imem_valid),
        .imem_addr(imem_addr),
        .imem_ready(imem_ready),
        .imem_rdata(imem_rdata),
        .trap(trap),
        .mtvec(mtvec),
        .mret(mret),
        .mepc(mepc),
        .pred_miss(pred_miss),
        .miss_addr(miss_addr),
        .fence(fence),
        .fence_npc(fence_npc),
        .fill(fill_bus.source)
    );

    fetch_buffer u_fetch_buffer (
        .clock(clock),
        .reset(reset),
        .fill(fill_bus.sink),
        .head(slot_bus.head)
    );

    issue_unit u_issue_unit (
        .issue(slot_bus.taker),
        .issue_ready(issue_ready),
        .issue0_valid(issue0_valid),
        .issue0_pc(issue0_pc),
        .issue0_instr(issue0_instr),
        .issue1_valid(issue1_valid),
        .issue1_pc(issue1_pc),
        .issue1_instr(issue1_instr)
    );

endmodule

`default_nettype wire

// File: sim/tb_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top;
    import fetch_pkg::*;

    // Five tests of about 200 cycles each plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [6:0] ADDI_OP = 7'b0010011;
    localparam logic [6:0] JAL_OP = 7'b1101111;

    logic clock = 1'b0;
    logic reset;
    logic imem_valid;
    addr_t imem_addr;
    logic imem_ready = 1'b0;
    word_t imem_rdata = '0;
    logic trap;
    addr_t mtvec;
    logic mret;
    addr_t mepc;
    logic pred_miss;
    addr_t miss_addr;
    logic fence;
    addr_t fence_npc;
    logic issue_ready;
    logic issue0_valid;
    addr_t issue0_pc;
    instr_t issue0_instr;
    logic issue1_valid;
    addr_t issue1_pc;
    instr_t issue1_instr;

    addr_t exp_pc = RESET_VECTOR;
    addr_t next_target = RESET_VECTOR;
    addr_t jal_pcs [$];
    int issued = 0;
    int pair_count = 0;
    int jal_alone_count = 0;
    int sb_errors = 0;
    int tb_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int mem_delay = 0;
    logic held_valid = 1'b0;
    logic held1_valid = 1'b0;
    addr_t held_pc;
    addr_t held1_pc;
    instr_t held_instr;
    instr_t held1_instr;
    logic prev_redirect = 1'b0;

    fetch_top u_dut (
        .clock(clock),
        .reset(reset),
        .imem_valid(imem_valid),
        .imem_addr(imem_addr),
        .imem_ready(imem_ready),
        .imem_rdata(imem_rdata),
        .trap(trap),
        .mtvec(mtvec),
        .mret(mret),
        .mepc(mepc),
        .pred_miss(pred_miss),
        .miss_addr(miss_addr),
        .fence(fence),
        .fence_npc(fence_npc),
        .issue_ready(issue_ready),
        .issue0_valid(issue0_valid),
        .issue0_pc(issue0_pc),
        .issue0_instr(issue0_instr),
        .issue1_valid(issue1_valid),
        .issue1_pc(issue1_pc),
        .issue1_instr(issue1_instr)
    );

    initial begin
        forever #20 clock = ~clock;
    end

    // Every pc holds an addi built from its address unless listed as a jal
    function automatic instr_t expect_instr(input addr_t p);
        instr_t instr;
        instr = {p[26:2], ADDI_OP};
        foreach (jal_pcs[i]) begin
            if (jal_pcs[i] == p) begin
                instr = {p[26:2], JAL_OP};
            end
        end
        return instr;
    endfunction

    function automatic word_t memory_word(input addr_t a);
        return {expect_instr({a[31:3], 3'b100}), expect_instr({a[31:3], 3'b000})};
    endfunction

    task automatic check_pc(input addr_t actual, input addr_t expected, input string what,
                            inout int errs);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errs++;
        end
    endtask

    task automatic check_instr(input instr_t actual, input instr_t expected, input string what,
                               inout int errs);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errs++;
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected, input string what,
                               inout int errs);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            errs++;
        end
    endtask

    task automatic check_slot(input addr_t pc, input instr_t instr);
        check_pc(pc, exp_pc, "issued pc", sb_errors);
        check_instr(instr, expect_instr(exp_pc), "issued instruction", sb_errors);
        // Resync so one slip reports once
        exp_pc = pc + 32'd4;
        issued++;
    endtask

    // Memory answers each request after a random wait
    always @(posedge clock) begin
        if (!reset) begin
            imem_ready <= 1'b0;
            mem_delay <= 0;
        end else if (imem_ready) begin
            imem_ready <= 1'b0;
        end else if (imem_valid) begin
            if (mem_delay == 0) begin
                mem_delay <= 1 + int'($urandom % 4);
            end else if (mem_delay == 1) begin
                imem_ready <= 1'b1;
                imem_rdata <= memory_word(imem_addr);
                mem_delay <= 0;
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end
    end

    // Scoreboard samples mid-cycle where the outputs are settled
    always @(negedge clock) begin
        if (reset) begin
            if (prev_redirect) begin
                check_valid(issue0_valid, 1'b0, "issue0_valid after flush", sb_errors);
                check_valid(issue1_valid, 1'b0, "issue1_valid after flush", sb_errors);
            end else if (held_valid) begin
                check_valid(issue0_valid, 1'b1, "held issue0_valid", sb_errors);
                check_pc(issue0_pc, held_pc, "held issue0_pc", sb_errors);
                check_instr(issue0_instr, held_instr, "held issue0_instr", sb_errors);
                if (held1_valid) begin
                    check_valid(issue1_valid, 1'b1, "held issue1_valid", sb_errors);
                    check_pc(issue1_pc, held1_pc, "held issue1_pc", sb_errors);
                    check_instr(issue1_instr, held1_instr, "held issue1_instr", sb_errors);
                end
            end
            // A low half always enters the buffer together with its partner
            if (issue0_valid && !issue0_pc[2] && issue0_instr[6:0] != JAL_OP) begin
                check_valid(issue1_valid, 1'b1, "issue1_valid beside a low half", sb_errors);
            end
            if (issue_ready && issue0_valid) begin
                if (issue0_instr[6:0] == JAL_OP) begin
                    check_valid(issue1_valid, 1'b0, "issue1_valid beside a jal", sb_errors);
                    if (!issue1_valid) begin
                        jal_alone_count++;
                    end
                end
                check_slot(issue0_pc, issue0_instr);
                if (issue1_valid) begin
                    check_slot(issue1_pc, issue1_instr);
                    pair_count++;
                end
            end
            held_valid = !issue_ready && issue0_valid;
            held1_valid = !issue_ready && issue1_valid;
            held_pc = issue0_pc;
            held1_pc = issue1_pc;
            held_instr = issue0_instr;
            held1_instr = issue1_instr;
            prev_redirect = trap || mret || pred_miss || fence;
            if (prev_redirect) begin
                exp_pc = next_target;
            end
        end
    end

    task automatic wait_issued(input int n);
        int target;
        target = issued + n;
        while (issued < target) begin
            @(posedge clock);
        end
    endtask

    task automatic pulse_redirect(input logic t, input logic m, input logic p, input logic f,
                                  input addr_t target);
        next_target = target;
        @(posedge clock);
        trap <= t;
        mret <= m;
        pred_miss <= p;
        fence <= f;
        @(posedge clock);
        trap <= 1'b0;
        mret <= 1'b0;
        pred_miss <= 1'b0;
        fence <= 1'b0;
    endtask

    task automatic report_test(input string name, input int start_errors);
        int new_errors;
        new_errors = sb_errors + tb_errors - start_errors;
        if (new_errors == 0) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", name, new_errors);
            tests_failed++;
        end
    endtask

    task automatic test_sequential();
        int start_errors;
        start_errors = sb_errors + tb_errors;
        @(negedge clock);
        check_valid(imem_valid, 1'b0, "imem_valid after reset", tb_errors);
        check_valid(issue0_valid, 1'b0, "issue0_valid after reset", tb_errors);
        check_pc(imem_addr, RESET_VECTOR, "first fetch address", tb_errors);
        wait_issued(40);
        report_test("sequential fetch", start_errors);
    endtask

    task automatic test_backpressure();
        int start_errors;
        start_errors = sb_errors + tb_errors;
        repeat (150) begin
            @(posedge clock);
            issue_ready <= ($urandom % 2) != 0;
        end
        @(posedge clock);
        issue_ready <= 1'b1;
        wait_issued(20);
        report_test("random back-pressure", start_errors);
    endtask

    task automatic test_priority();
        int start_errors;
        start_errors = sb_errors + tb_errors;
        @(posedge clock);
        mtvec <= 32'h0000_4000;
        mepc <= 32'h0000_5000;
        miss_addr <= 32'h0000_6000;
        fence_npc <= 32'h0000_7000;
        pulse_redirect(1'b1, 1'b1, 1'b1, 1'b0, 32'h0000_4000);
        wait_issued(8);
        pulse_redirect(1'b0, 1'b1, 1'b1, 1'b0, 32'h0000_5000);
        wait_issued(8);
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_6000);
        wait_issued(8);
        pulse_redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_7000);
        wait_issued(8);
        report_test("redirect priority", start_errors);
    endtask

    task automatic test_stale_redirect();
        int start_errors;
        start_errors = sb_errors + tb_errors;
        @(posedge clock);
        miss_addr <= 32'h0000_8004;
        // A request the memory will not answer at the coming edge
        @(negedge clock);
        while (!(imem_valid && !imem_ready && mem_delay != 1)) begin
            @(negedge clock);
        end
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_8004);
        wait_issued(12);
        report_test("redirect during a request", start_errors);
    endtask

    task automatic test_jal_pairing();
        int start_errors;
        int jal_before;
        int pairs_before;
        start_errors = sb_errors + tb_errors;
        jal_pcs.push_back(32'h0000_9010);
        jal_before = jal_alone_count;
        pairs_before = pair_count;
        @(posedge clock);
        miss_addr <= 32'h0000_9010;
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_9010);
        wait_issued(16);
        if (jal_alone_count == jal_before) begin
            $display("The jal at 00009010 was never issued alone in slot 0");
            tb_errors++;
        end
        if (pair_count == pairs_before) begin
            $display("No two instructions were issued together after the jal");
            tb_errors++;
        end
        report_test("jal pairing", start_errors);
    endtask

    initial begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(59913));
        reset = 1'b0;
        trap = 1'b0;
        mret = 1'b0;
        pred_miss = 1'b0;
        fence = 1'b0;
        mtvec = '0;
        mepc = '0;
        miss_addr = '0;
        fence_npc = '0;
        issue_ready = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        test_sequential();
        test_backpressure();
        test_priority();
        test_stale_redirect();
        test_jal_pairing();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && sb_errors + tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/fetch_pkg.sv
src/fetch_fill_if.sv
src/slot_pair_if.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/issue_unit.sv
src/fetch_top.sv
sim/tb_fetch_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_fetch_top -f compile.f \
    -o tb_fetch_top \
    && ./obj_dir/tb_fetch_top | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
